//--- bench/histTopTb.sv
`timescale 1ns/1ns

module histTopTb import histDataPkg::*; ();

    localparam int PIXEL_NUM   = 4;
    localparam int ACQ_NUM     = 3;
    localparam int BINS        = 1 << BIN_BITS;
    localparam int SWEEP_LIMIT = PIXEL_NUM * BINS + 16;

    // one stimulus cycle
    typedef struct packed {
        logic [3:0] frame;
        logic       valid;
        hitT        hit;
        logic       acqEnd;
    } rowT;

    logic clk;
    logic res;
    logic hitValid;
    hitT  hit;
    logic acqEnd;
    logic busy;
    logic peakValid;
    peakT peak;

    rowT  rows[$];
    int   refHist [PIXEL_NUM][BINS];
    peakT expPeak [PIXEL_NUM];
    int   acqSeen;

    histTop #(
        .PIXEL_NUM (PIXEL_NUM),
        .ACQ_NUM   (ACQ_NUM)
    ) DUT (
        .clk       (clk),
        .res       (res),
        .hitValid  (hitValid),
        .hit       (hit),
        .acqEnd    (acqEnd),
        .busy      (busy),
        .peakValid (peakValid),
        .peak      (peak)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stopRun(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic checkPeak(input string name, input peakT expected, input peakT actual);
        if (actual !== expected) begin
            stopRun($sformatf("FAIL %s expected pixel %0d bin %0d count %0d %s",
                name, expected.pixel, expected.bin, expected.count,
                $sformatf("actual pixel %0d bin %0d count %0d",
                    actual.pixel, actual.bin, actual.count)));
        end
    endtask

    task automatic checkLevel(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            stopRun($sformatf("FAIL %s expected %b actual %b", name, expected, actual));
        end
    endtask

    // the bound checker counts its failed assertions
    always @(negedge clk) begin
        if (DUT.props.failCount != 0) begin
            stopRun("a bound assertion failed during the run");
        end
    end

    function automatic void addRow(input int frame, input logic valid, input int pixel,
                                   input int bin, input logic acq);
        rowT r;
        r.frame     = 4'(frame);
        r.valid     = valid;
        r.hit.pixel = PIXEL_BITS'(pixel);
        r.hit.bin   = BIN_BITS'(bin);
        r.acqEnd    = acq;
        rows.push_back(r);
    endfunction

    // first bin with the largest count wins
    // model is cleared afterwards
    function automatic void closeFrame();
        int best;
        int bestBin;
        for (int p = 0; p < PIXEL_NUM; p++) begin
            best    = refHist[p][0];
            bestBin = 0;
            for (int b = 1; b < BINS; b++) begin
                if (refHist[p][b] > best) begin
                    best    = refHist[p][b];
                    bestBin = b;
                end
            end
            expPeak[p].pixel = PIXEL_BITS'(p);
            expPeak[p].bin   = BIN_BITS'(bestBin);
            expPeak[p].count = COUNT_BITS'(best);
            for (int b = 0; b < BINS; b++) begin
                refHist[p][b] = 0;
            end
        end
    endfunction

    // wait for busy low with no result on the way
    task automatic waitIdle(input int limit, input string what);
        int n;
        n = 0;
        while (busy) begin
            @(negedge clk);
            n++;
            if (peakValid) begin
                stopRun($sformatf("unexpected peakValid while waiting for %s to end", what));
            end
            if (n > limit) begin
                stopRun($sformatf("timeout waiting for busy to fall after %s", what));
            end
        end
    endtask

    task automatic waitBusy(input int limit, input int frame);
        int n;
        n = 0;
        while (!busy) begin
            @(negedge clk);
            n++;
            if (n > limit) begin
                stopRun($sformatf("timeout waiting for busy to rise in frame %0d", frame));
            end
        end
    endtask

    task automatic waitPeak(input int limit, input int frame);
        int n;
        n = 0;
        @(negedge clk);
        while (!peakValid) begin
            n++;
            if (n > limit) begin
                stopRun($sformatf("timeout waiting for peakValid in frame %0d", frame));
            end
            @(negedge clk);
        end
    endtask

    // one peak per pixel in pixel order
    task automatic collectFrame(input int frame);
        @(negedge clk);
        waitBusy(8, frame);
        for (int p = 0; p < PIXEL_NUM; p++) begin
            waitPeak(BINS + 8, frame);
            checkPeak($sformatf("frame %0d pixel %0d", frame, p), expPeak[p], peak);
        end
        waitIdle(4, $sformatf("frame %0d", frame));
    endtask

    task automatic buildTable();
        // frame 0 has no hits
        repeat (3) addRow(0, 1'b0, 0, 0, 1'b1);
        // one hit per pixel
        // last one shares its cycle with acqEnd
        addRow(1, 1'b1, 0, 5, 1'b0);
        addRow(1, 1'b1, 1, 9, 1'b0);
        addRow(1, 1'b1, 2, 0, 1'b0);
        addRow(1, 1'b1, 3, 15, 1'b1);
        repeat (2) addRow(1, 1'b0, 0, 0, 1'b1);
        // back-to-back same bin then alternating bins ending in a tie
        repeat (3) addRow(2, 1'b1, 1, 3, 1'b0);
        addRow(2, 1'b1, 2, 7, 1'b0);
        addRow(2, 1'b1, 2, 8, 1'b0);
        addRow(2, 1'b1, 2, 7, 1'b0);
        addRow(2, 1'b1, 2, 8, 1'b1);
        repeat (2) addRow(2, 1'b0, 0, 0, 1'b1);
        // tie spread over all acquisitions
        // frame 2 counts must be gone
        addRow(3, 1'b1, 0, 10, 1'b1);
        addRow(3, 1'b1, 0, 4, 1'b0);
        addRow(3, 1'b1, 0, 10, 1'b1);
        addRow(3, 1'b1, 0, 4, 1'b0);
        addRow(3, 1'b1, 3, 2, 1'b1);
        // random frame with acquisitions ending at hits 13, 26 and 39
        for (int i = 0; i < 40; i++) begin
            addRow(4, 1'b1, $urandom % PIXEL_NUM, $urandom % BINS, (i % 13 == 0) && (i != 0));
        end
    endtask

    initial begin
        rowT r;
        res      = 1'b0;
        hitValid = 1'b0;
        hit      = '0;
        acqEnd   = 1'b0;
        acqSeen  = 0;
        void'($urandom(32'h5fcc8afc));
        buildTable();
        repeat (16) @(posedge clk);
        res <= 1'b1;
        @(negedge clk);
        checkLevel("busy after reset", 1'b1, busy);
        waitIdle(SWEEP_LIMIT, "clear sweep");
        foreach (rows[i]) begin
            r = rows[i];
            @(negedge clk);
            checkLevel($sformatf("frame %0d busy before row %0d", r.frame, i), 1'b0, busy);
            @(posedge clk);
            hitValid <= r.valid;
            hit      <= r.hit;
            acqEnd   <= r.acqEnd;
            if (r.valid && (r.hit.pixel < PIXEL_NUM)) begin
                refHist[r.hit.pixel][r.hit.bin]++;
            end
            if (r.acqEnd) begin
                acqSeen++;
            end
            if (acqSeen == ACQ_NUM) begin
                acqSeen = 0;
                closeFrame();
                @(posedge clk);
                hitValid <= 1'b0;
                acqEnd   <= 1'b0;
                collectFrame(r.frame);
            end
        end
        if (DUT.props.failCount != 0) begin
            $display("%0d assertion failures during the run", DUT.props.failCount);
            $display("TEST FAILED");
            $fatal(1, "assertion failures");
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

//--- bench/histTop_properties.sv
`timescale 1ns/1ns

module histTopProperties import histCtrlPkg::*; (
    input logic     clk,
    input logic     res,
    input logic     busy,
    input logic     peakValid,
    input logic     hisBuildDone,
    input memReadT  builderRead,
    input memWriteT builderWrite,
    input memWriteT scanWrite
);

    // number of property failures so far
    int failCount = 0;

    // results only come out of a running scan
    peakInScan: assert property (@(posedge clk) disable iff (!res) peakValid |-> busy)
        else begin
            $error("peakValid high while busy is low");
            failCount++;
        end

    // the two ram clients never write together
    writeExclusive: assert property (@(posedge clk) disable iff (!res)
        !(builderWrite.en && scanWrite.en))
        else begin
            $error("builder and scan write enables both high");
            failCount++;
        end

    // frame handoff is a single-cycle strobe
    doneStrobe: assert property (@(posedge clk) disable iff (!res)
        hisBuildDone |=> !hisBuildDone)
        else begin
            $error("hisBuildDone high for more than one cycle");
            failCount++;
        end

    // builder stays off the ram during a sweep
    noBuilderRead: assert property (@(posedge clk) disable iff (!res)
        busy |-> !builderRead.en)
        else begin
            $error("builder read enabled while busy is high");
            failCount++;
        end

endmodule

bind histTop histTopProperties props (
    .clk          (clk),
    .res          (res),
    .busy         (busy),
    .peakValid    (peakValid),
    .hisBuildDone (hisBuildDone),
    .builderRead  (builderRead),
    .builderWrite (builderWrite),
    .scanWrite    (scanWrite)
);

//--- source/hisBuilder.sv
`timescale 1ns/1ns

module hisBuilder import histDataPkg::*, histCtrlPkg::*; #(
    parameter int PIXEL_NUM = 4,
    parameter int ACQ_NUM   = 3
) (
    input  logic                  clk,
    input  logic                  res,
    input  logic                  hitValid,
    input  hitT                   hit,
    input  logic                  acqEnd,
    input  logic                  busy,
    input  logic [COUNT_BITS-1:0] rdData,
    output memReadT               builderRead,
    output memWriteT              builderWrite,
    output logic                  hisBuildDone
);

    localparam int ACQ_BITS = (ACQ_NUM > 1) ? $clog2(ACQ_NUM) : 1;
    localparam logic [ACQ_BITS-1:0] ACQ_LAST = ACQ_BITS'(ACQ_NUM - 1);

    builderStateT state;
    builderStateT stateNext;

    logic [ACQ_BITS-1:0]      acqCnt;
    logic                     hitTake;
    logic                     acqTake;
    logic                     acqWrap;
    logic [MEM_ADDR_BITS-1:0] hitAddr;

    // write stage of the pipeline
    logic                     wrValid;
    logic [MEM_ADDR_BITS-1:0] wrAddr;

    // last written count, for a re-read of the same address
    logic                     fwdValid;
    logic [COUNT_BITS-1:0]    fwdCount;

    logic [COUNT_BITS-1:0]    baseCount;
    logic [COUNT_BITS-1:0]    newCount;

    assign hitAddr = {hit.pixel, hit.bin};

    // no hits while the peak finder owns the ram or the frame is closing
    // pixels past the active array are dropped
    assign hitTake = hitValid && !busy && (state != FLUSH) && (hit.pixel < PIXEL_NUM);
    assign acqTake = acqEnd && !busy && (state != FLUSH);
    assign acqWrap = acqTake && (acqCnt == ACQ_LAST);

    always_comb begin
        stateNext = state;
        case (state)
            IDLE: begin
                // a single-acquisition frame can close right away
                if (acqWrap) begin
                    stateNext = FLUSH;
                end else if (hitTake || acqTake) begin
                    stateNext = COLLECT;
                end
            end
            COLLECT: begin
                if (acqWrap) begin
                    stateNext = FLUSH;
                end
            end
            FLUSH: begin
                // wait for the last increment to land
                if (!wrValid) begin
                    stateNext = IDLE;
                end
            end
            default: begin
                stateNext = IDLE;
            end
        endcase
    end

    // one cycle, FLUSH always leaves on it
    assign hisBuildDone = (state == FLUSH) && !wrValid;

    // stale ram data if the previous cycle wrote the same bin
    assign baseCount = fwdValid ? fwdCount : rdData;
    assign newCount  = baseCount + 1'b1;

    always_comb begin
        builderRead.en     = hitTake;
        builderRead.addr   = hitAddr;
        builderWrite.en    = wrValid;
        builderWrite.addr  = wrAddr;
        builderWrite.data  = newCount;
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state    <= IDLE;
            acqCnt   <= '0;
            wrValid  <= 1'b0;
            fwdValid <= 1'b0;
        end else begin
            state   <= stateNext;
            wrValid <= hitTake;
            // next read hits the address written now
            fwdValid <= hitTake && wrValid && (hitAddr == wrAddr);
            if (acqTake) begin
                acqCnt <= acqWrap ? '0 : acqCnt + 1'b1;
            end
        end
    end

    // pipeline payload
    always_ff @(posedge clk) begin
        wrAddr   <= hitAddr;
        fwdCount <= newCount;
    end

endmodule

//--- source/histCtrlPkg.sv
package histCtrlPkg;

    import histDataPkg::*;

    // ram address is {pixel, bin}
    localparam int MEM_ADDR_BITS = PIXEL_BITS + BIN_BITS;

    // write request into the histogram ram
    typedef struct packed {
        logic                     en;
        logic [MEM_ADDR_BITS-1:0] addr;
        logic [COUNT_BITS-1:0]    data;
    } memWriteT;

    // read request, data comes back one cycle later
    typedef struct packed {
        logic                     en;
        logic [MEM_ADDR_BITS-1:0] addr;
    } memReadT;

    // histogram builder FSM
    typedef enum logic [1:0] {
        IDLE,
        COLLECT,
        FLUSH
    } builderStateT;

    // peak finder sweep operation
    // clear only zeroes, peak reads and zeroes
    typedef enum logic [1:0] {
        SCAN_NONE,
        SCAN_CLEAR,
        SCAN_PEAK
    } scanOpT;

endpackage

//--- source/histDataPkg.sv
package histDataPkg;

    // tdc bin code width, 16 bins per pixel
    localparam int BIN_BITS = 4;

    // histogram count width, counts wrap
    localparam int COUNT_BITS = 8;

    // pixel index width, up to 16 pixels
    localparam int PIXEL_BITS = 4;

    // one photon hit from the array
    typedef struct packed {
        logic [PIXEL_BITS-1:0] pixel;
        logic [BIN_BITS-1:0]   bin;
    } hitT;

    // peak result of one pixel
    // bin is the first bin holding the maximum
    typedef struct packed {
        logic [PIXEL_BITS-1:0] pixel;
        logic [BIN_BITS-1:0]   bin;
        logic [COUNT_BITS-1:0] count;
    } peakT;

endpackage

//--- source/histMemory.sv
`timescale 1ns/1ns

module histMemory import histDataPkg::*, histCtrlPkg::*; (
    input  logic                  clk,
    input  memReadT               builderRead,
    input  memWriteT              builderWrite,
    input  memReadT               scanRead,
    input  memWriteT              scanWrite,
    output logic [COUNT_BITS-1:0] rdData
);

    // one count per {pixel, bin}
    logic [COUNT_BITS-1:0] countMem [1 << MEM_ADDR_BITS];

    memWriteT wrSel;
    memReadT  rdSel;

    // scan side wins, clients never overlap anyway
    assign wrSel = scanWrite.en ? scanWrite : builderWrite;
    assign rdSel = scanRead.en ? scanRead : builderRead;

    // write port
    always_ff @(posedge clk) begin
        if (wrSel.en) begin
            countMem[wrSel.addr] <= wrSel.data;
        end
    end

    // read port, registered
    // same-address write in this cycle returns the old value
    always_ff @(posedge clk) begin
        if (rdSel.en) begin
            rdData <= countMem[rdSel.addr];
        end
    end

endmodule

//--- source/histTop.sv
`timescale 1ns/1ns

module histTop import histDataPkg::*, histCtrlPkg::*; #(
    parameter int PIXEL_NUM = 4,
    parameter int ACQ_NUM   = 3
) (
    input  logic clk,
    input  logic res,
    input  logic hitValid,
    input  hitT  hit,
    input  logic acqEnd,
    output logic busy,
    output logic peakValid,
    output peakT peak
);

    // builder side of the ram
    memReadT  builderRead;
    memWriteT builderWrite;

    // peak finder side of the ram
    memReadT  scanRead;
    memWriteT scanWrite;

    // shared read data, owner follows busy
    logic [COUNT_BITS-1:0] rdData;

    // frame handoff builder to peak finder
    logic hisBuildDone;

    hisBuilder #(
        .PIXEL_NUM (PIXEL_NUM),
        .ACQ_NUM   (ACQ_NUM)
    ) builder (
        .clk          (clk),
        .res          (res),
        .hitValid     (hitValid),
        .hit          (hit),
        .acqEnd       (acqEnd),
        .busy         (busy),
        .rdData       (rdData),
        .builderRead  (builderRead),
        .builderWrite (builderWrite),
        .hisBuildDone (hisBuildDone)
    );

    peakFinder #(
        .PIXEL_NUM (PIXEL_NUM)
    ) finder (
        .clk          (clk),
        .res          (res),
        .hisBuildDone (hisBuildDone),
        .rdData       (rdData),
        .scanRead     (scanRead),
        .scanWrite    (scanWrite),
        .busy         (busy),
        .peakValid    (peakValid),
        .peak         (peak)
    );

    histMemory memory (
        .clk          (clk),
        .builderRead  (builderRead),
        .builderWrite (builderWrite),
        .scanRead     (scanRead),
        .scanWrite    (scanWrite),
        .rdData       (rdData)
    );

endmodule

//--- source/peakFinder.sv
`timescale 1ns/1ns

module peakFinder import histDataPkg::*, histCtrlPkg::*; #(
    parameter int PIXEL_NUM = 4
) (
    input  logic                  clk,
    input  logic                  res,
    input  logic                  hisBuildDone,
    input  logic [COUNT_BITS-1:0] rdData,
    output memReadT               scanRead,
    output memWriteT              scanWrite,
    output logic                  busy,
    output logic                  peakValid,
    output peakT                  peak
);

    // last bin of the last active pixel
    localparam logic [MEM_ADDR_BITS-1:0] LAST_ADDR =
        MEM_ADDR_BITS'(PIXEL_NUM * (1 << BIN_BITS) - 1);

    scanOpT op;

    // clear sweep request, set by reset
    logic clearReq;

    logic [MEM_ADDR_BITS-1:0] addrCnt;
    logic                     scanning;
    logic                     lastAddr;

    // read data stage
    logic                     rdLive;
    logic [PIXEL_BITS-1:0]    rdPixel;
    logic [BIN_BITS-1:0]      rdBin;

    // running peak of the current pixel
    logic [COUNT_BITS-1:0]    maxCount;
    logic [BIN_BITS-1:0]      maxBin;

    logic                     firstBin;
    logic                     lastBin;
    logic                     take;
    logic [COUNT_BITS-1:0]    candCount;
    logic [BIN_BITS-1:0]      candBin;

    assign scanning = (op != SCAN_NONE);
    assign lastAddr = (addrCnt == LAST_ADDR);

    // every visited bin is zeroed
    // read only needed for the peak search
    always_comb begin
        scanRead.en     = (op == SCAN_PEAK);
        scanRead.addr   = addrCnt;
        scanWrite.en    = scanning;
        scanWrite.addr  = addrCnt;
        scanWrite.data  = '0;
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            op       <= SCAN_NONE;
            clearReq <= 1'b1;
            addrCnt  <= '0;
        end else begin
            clearReq <= 1'b0;
            if (clearReq) begin
                op <= SCAN_CLEAR;
            end else if (hisBuildDone) begin
                op <= SCAN_PEAK;
            end else if (scanning && lastAddr) begin
                op <= SCAN_NONE;
            end
            if (scanning) begin
                addrCnt <= lastAddr ? '0 : addrCnt + 1'b1;
            end
        end
    end

    // data of a peak read comes back next cycle
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            rdLive    <= 1'b0;
            peakValid <= 1'b0;
        end else begin
            rdLive    <= (op == SCAN_PEAK);
            peakValid <= rdLive && lastBin;
        end
    end

    always_ff @(posedge clk) begin
        rdPixel <= addrCnt[MEM_ADDR_BITS-1:BIN_BITS];
        rdBin   <= addrCnt[BIN_BITS-1:0];
    end

    assign firstBin = (rdBin == '0);
    assign lastBin  = (rdBin == '1);

    // strictly greater keeps the first bin of a tie
    assign take      = firstBin || (rdData > maxCount);
    assign candCount = take ? rdData : maxCount;
    assign candBin   = take ? rdBin : maxBin;

    always_ff @(posedge clk) begin
        if (rdLive) begin
            maxCount <= candCount;
            maxBin   <= candBin;
        end
        // result includes the final bin itself
        if (rdLive && lastBin) begin
            peak.pixel <= rdPixel;
            peak.bin   <= candBin;
            peak.count <= candCount;
        end
    end

    // covers reset request, sweep and the two drain cycles
    assign busy = clearReq || scanning || rdLive || peakValid;

endmodule

//--- sources.f
source/histDataPkg.sv
source/histCtrlPkg.sv
source/histMemory.sv
source/hisBuilder.sv
source/peakFinder.sv
source/histTop.sv
bench/histTop_properties.sv
bench/histTopTb.sv
